/* Makefile */
# Verilator build and run for the execute stage

VERILATOR  ?= verilator
TOP        ?= tb_execute
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "FAIL: pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
rv32_exec_pkg.sv
fu_alu.sv
fu_mul.sv
fu_div.sv
fu_branch.sv
execute.sv
tb_execute.sv

/* execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,

    input  logic                           start_alu,
    input  logic                           start_mul,
    input  logic                           start_div,
    input  logic                           start_br,

    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v_alu,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v_alu,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v_mul,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v_mul,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v_div,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v_div,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v_br,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v_br,

    input  rv32_exec_pkg::decode_info_t    decode_alu,
    input  rv32_exec_pkg::decode_info_t    decode_mul,
    input  rv32_exec_pkg::decode_info_t    decode_div,
    input  rv32_exec_pkg::decode_info_t    decode_br,

    input  rv32_exec_pkg::fu_tag_t         tag_alu,
    input  rv32_exec_pkg::fu_tag_t         tag_mul,
    input  rv32_exec_pkg::fu_tag_t         tag_div,
    input  rv32_exec_pkg::fu_tag_t         tag_br,

    output rv32_exec_pkg::cdb_t            cdb_alu,
    output rv32_exec_pkg::cdb_t            cdb_mul,
    output rv32_exec_pkg::cdb_t            cdb_div,
    output rv32_exec_pkg::cdb_t            cdb_br,
    output logic                           busy_div
);

    logic start_alu_g;
    logic start_mul_g;
    logic start_div_g;
    logic start_br_g;

    logic [rv32_exec_pkg::XLEN-1:0] rd_v_alu;
    logic [rv32_exec_pkg::XLEN-1:0] rd_v_div;
    logic                           valid_div;
    rv32_exec_pkg::cdb_t            mul_result;
    rv32_exec_pkg::cdb_t            br_result;

    // tags for the one divide in flight
    rv32_exec_pkg::fu_tag_t div_tag;
    rv32_exec_pkg::inst_u   div_inst;

    // nothing issues in a flush cycle
    assign start_alu_g = start_alu && !flush;
    assign start_mul_g = start_mul && !flush;
    assign start_div_g = start_div && !flush;
    assign start_br_g  = start_br && !flush;

    always_ff @(posedge clk) begin
        if (start_div_g) begin
            div_tag  <= tag_div;
            div_inst <= decode_div.inst;
        end
    end

    fu_alu u_alu (
        .rs1_v       (rs1_v_alu),
        .rs2_v       (rs2_v_alu),
        .decode_info (decode_alu),
        .rd_v        (rd_v_alu)
    );

    fu_mul u_mul (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start_mul_g),
        .rs1_v       (rs1_v_mul),
        .rs2_v       (rs2_v_mul),
        .decode_info (decode_mul),
        .tag         (tag_mul),
        .result      (mul_result)
    );

    fu_div u_div (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start_div_g),
        .rs1_v       (rs1_v_div),
        .rs2_v       (rs2_v_div),
        .decode_info (decode_div),
        .rd_v        (rd_v_div),
        .valid       (valid_div),
        .busy        (busy_div)
    );

    fu_branch u_br (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (start_br_g),
        .rs1_v       (rs1_v_br),
        .rs2_v       (rs2_v_br),
        .decode_info (decode_br),
        .tag         (tag_br),
        .result      (br_result)
    );

    always_comb begin
        cdb_alu = '0;
        if (start_alu_g) begin
            cdb_alu.valid = 1'b1;
            cdb_alu.tag   = tag_alu;
            cdb_alu.rd_v  = rd_v_alu;
            cdb_alu.inst  = decode_alu.inst;
        end

        cdb_div = '0;
        if (valid_div) begin
            cdb_div.valid = 1'b1;
            cdb_div.tag   = div_tag;
            cdb_div.rd_v  = rd_v_div;
            cdb_div.inst  = div_inst;
        end

        cdb_mul = mul_result;
        cdb_br  = br_result;

        // registered results are still live during the flush cycle
        if (flush) begin
            cdb_alu = '0;
            cdb_mul = '0;
            cdb_div = '0;
            cdb_br  = '0;
        end
    end

    // nothing issued before a flush may come back afterwards
    flush_drains: assert property (@(posedge clk) disable iff (rst)
        flush |=> !(cdb_mul.valid || cdb_div.valid || cdb_br.valid || busy_div));

endmodule

`default_nettype wire

/* fu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_alu (
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v,
    input  rv32_exec_pkg::decode_info_t    decode_info,
    output logic [rv32_exec_pkg::XLEN-1:0] rd_v
);

    rv32_exec_pkg::r_fmt_t          ir;
    logic [rv32_exec_pkg::XLEN-1:0] opb;
    logic [4:0]                     shamt;
    logic                           is_reg;
    logic                           is_sub;
    logic                           is_sra;

    assign ir     = decode_info.inst.r;
    assign opb    = decode_info.use_imm ? decode_info.i_imm : rs2_v;
    assign shamt  = opb[4:0];
    assign is_reg = ir.opcode == rv32_exec_pkg::OP_REG;

    // no subtract in the immediate form
    assign is_sub = is_reg && ir.funct7 == rv32_exec_pkg::F7_ALT;

    // srai carries the same bit in imm[11:5]
    assign is_sra = (is_reg || ir.opcode == rv32_exec_pkg::OP_IMM) &&
                    ir.funct7 == rv32_exec_pkg::F7_ALT;

    always_comb begin
        rd_v = '0;
        case (ir.funct3)
            rv32_exec_pkg::F3_ADD:  rd_v = is_sub ? rs1_v - opb : rs1_v + opb;
            rv32_exec_pkg::F3_SLL:  rd_v = rs1_v << shamt;
            rv32_exec_pkg::F3_SLT:  rd_v[0] = $signed(rs1_v) < $signed(opb);
            rv32_exec_pkg::F3_SLTU: rd_v[0] = rs1_v < opb;
            rv32_exec_pkg::F3_XOR:  rd_v = rs1_v ^ opb;
            rv32_exec_pkg::F3_SR: begin
                // sra fills with the sign bit, srl with zeros
                if (is_sra) begin
                    rd_v = $signed(rs1_v) >>> shamt;
                end else begin
                    rd_v = rs1_v >> shamt;
                end
            end
            rv32_exec_pkg::F3_OR:   rd_v = rs1_v | opb;
            rv32_exec_pkg::F3_AND:  rd_v = rs1_v & opb;
        endcase
    end

endmodule

`default_nettype wire

/* fu_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_branch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           start,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v,
    input  rv32_exec_pkg::decode_info_t    decode_info,
    input  rv32_exec_pkg::fu_tag_t         tag,
    output rv32_exec_pkg::cdb_t            result
);

    localparam int W = rv32_exec_pkg::XLEN;

    rv32_exec_pkg::b_fmt_t ib;
    rv32_exec_pkg::cdb_t   nxt;
    logic [W-1:0]          offset;
    logic                  eq;
    logic                  lt;
    logic                  ltu;
    logic                  cond;
    logic                  taken;

    assign ib  = decode_info.inst.b;
    assign eq  = rs1_v == rs2_v;
    assign lt  = $signed(rs1_v) < $signed(rs2_v);
    assign ltu = rs1_v < rs2_v;

    // B-type immediate, bit 0 always clear
    assign offset = {{(W-12){ib.imm12}}, ib.imm11, ib.imm10_5, ib.imm4_1, 1'b0};

    always_comb begin
        case (ib.funct3)
            rv32_exec_pkg::F3_BEQ:  cond = eq;
            rv32_exec_pkg::F3_BNE:  cond = !eq;
            rv32_exec_pkg::F3_BLT:  cond = lt;
            rv32_exec_pkg::F3_BGE:  cond = !lt;
            rv32_exec_pkg::F3_BLTU: cond = ltu;
            rv32_exec_pkg::F3_BGEU: cond = !ltu;
            default:                cond = 1'b0;
        endcase
    end

    assign taken = cond && ib.opcode == rv32_exec_pkg::OP_BRANCH;

    always_comb begin
        nxt           = '0;
        nxt.valid     = 1'b1;
        nxt.tag       = tag;
        nxt.inst      = decode_info.inst;
        nxt.pc_select = taken;
        nxt.pc_branch = decode_info.pc + (taken ? offset : 32'd4);
    end

    // idle cycles leave an empty record
    always_ff @(posedge clk) begin
        if (rst || flush || !start) begin
            result <= '0;
        end else begin
            result <= nxt;
        end
    end

endmodule

`default_nettype wire

/* fu_div.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_div (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           start,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v,
    input  rv32_exec_pkg::decode_info_t    decode_info,
    output logic [rv32_exec_pkg::XLEN-1:0] rd_v,
    output logic                           valid,
    output logic                           busy
);

    typedef struct packed {
        logic is_rem;
        logic neg_q;
        logic neg_r;
    } div_op_t;

    localparam int W    = rv32_exec_pkg::XLEN;
    localparam int LAST = rv32_exec_pkg::DIV_CYCLES - 1;

    logic [2:0]   f3;
    logic         op_signed;
    logic [W-1:0] abs_a;
    logic [W-1:0] abs_b;
    logic         run;
    logic         iterate;
    logic         finish;
    logic [$clog2(rv32_exec_pkg::DIV_CYCLES)-1:0] count;
    div_op_t      op;

    logic [W-1:0] rem;
    logic [W-1:0] quo;
    logic [W-1:0] dvs;
    logic [W-1:0] rem_in;
    logic [W-1:0] quo_in;
    logic [W-1:0] dvs_in;
    logic [W:0]   rem_sh;
    logic [W:0]   rem_sub;
    logic         q_bit;
    logic [W-1:0] rem_nx;
    logic [W-1:0] quo_nx;
    logic [W-1:0] q_fix;
    logic [W-1:0] r_fix;

    assign f3        = decode_info.inst.r.funct3;
    assign op_signed = f3 == rv32_exec_pkg::F3_DIV || f3 == rv32_exec_pkg::F3_REM;
    assign abs_a     = (op_signed && rs1_v[W-1]) ? -rs1_v : rs1_v;
    assign abs_b     = (op_signed && rs2_v[W-1]) ? -rs2_v : rs2_v;

    // the start edge already runs the first iteration
    assign iterate = start || (run && count != LAST);
    assign finish  = run && count == LAST;
    assign busy    = run;

    // one restoring step
    always_comb begin
        rem_in  = start ? '0 : rem;
        quo_in  = start ? abs_a : quo;
        dvs_in  = start ? abs_b : dvs;
        rem_sh  = {rem_in, quo_in[W-1]};
        rem_sub = rem_sh - {1'b0, dvs_in};
        q_bit   = !rem_sub[W];
        rem_nx  = q_bit ? rem_sub[W-1:0] : rem_sh[W-1:0];
        quo_nx  = {quo_in[W-2:0], q_bit};
    end

    // x/0 leaves all ones in quo and x in rem, so only the quotient sign is held back.
    // min/-1 falls out of the unsigned path as min and 0.
    assign q_fix = op.neg_q ? -quo : quo;
    assign r_fix = op.neg_r ? -rem : rem;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            run   <= 1'b0;
            valid <= 1'b0;
            count <= '0;
        end else begin
            valid <= finish;
            if (start) begin
                run   <= 1'b1;
                count <= '0;
            end else if (finish) begin
                run <= 1'b0;
            end else if (run) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iterate) begin
            rem <= rem_nx;
            quo <= quo_nx;
        end
        if (start) begin
            dvs       <= abs_b;
            op.is_rem <= !(f3 == rv32_exec_pkg::F3_DIV || f3 == rv32_exec_pkg::F3_DIVU);
            op.neg_q  <= op_signed && (rs1_v[W-1] ^ rs2_v[W-1]) && |rs2_v;
            op.neg_r  <= op_signed && rs1_v[W-1];
        end
        if (finish) begin
            rd_v <= op.is_rem ? r_fix : q_fix;
        end
    end

    no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

`default_nettype wire

/* fu_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_mul (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           start,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs1_v,
    input  logic [rv32_exec_pkg::XLEN-1:0] rs2_v,
    input  rv32_exec_pkg::decode_info_t    decode_info,
    input  rv32_exec_pkg::fu_tag_t         tag,
    output rv32_exec_pkg::cdb_t            result
);

    // sideband that rides along with each stage
    typedef struct packed {
        rv32_exec_pkg::fu_tag_t tag;
        rv32_exec_pkg::inst_u   inst;
    } mul_ctl_t;

    localparam int W    = rv32_exec_pkg::XLEN;
    localparam int LAST = rv32_exec_pkg::MUL_STAGES - 1;

    logic [rv32_exec_pkg::MUL_STAGES-1:0] vld;
    mul_ctl_t                             ctl [rv32_exec_pkg::MUL_STAGES];

    logic [2:0]            f3_in;
    logic                  a_signed;
    logic                  b_signed;
    logic signed [W:0]     s1_a;
    logic signed [W:0]     s1_b;
    logic signed [2*W+1:0] s2_lo;
    logic signed [2*W+1:0] s2_hi;
    logic signed [2*W+1:0] s3_sum;
    logic [2*W-1:0]        s3_prod;
    logic [W-1:0]          s4_word;

    assign f3_in    = decode_info.inst.r.funct3;
    assign a_signed = f3_in != rv32_exec_pkg::F3_MULHU;
    assign b_signed = f3_in == rv32_exec_pkg::F3_MULH || f3_in == rv32_exec_pkg::F3_MUL;
    assign s3_sum   = s2_lo + (s2_hi <<< (W / 2));

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            vld <= '0;
        end else begin
            vld <= {vld[LAST-1:0], start};
        end
    end

    always_ff @(posedge clk) begin
        ctl[0].tag  <= tag;
        ctl[0].inst <= decode_info.inst;
        for (int i = 1; i <= LAST; i++) begin
            ctl[i] <= ctl[i-1];
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 sign or zero extends both operands to 33 bits
        s1_a <= {a_signed & rs1_v[W-1], rs1_v};
        s1_b <= {b_signed & rs2_v[W-1], rs2_v};
        // stage 2 splits b into an unsigned low half and a signed high part
        s2_lo <= s1_a * $signed({1'b0, s1_b[W/2-1:0]});
        s2_hi <= s1_a * $signed(s1_b[W:W/2]);
        // stage 3 adds the partial products
        s3_prod <= s3_sum[2*W-1:0];
        // stage 4 picks the low or high word
        if (ctl[LAST-1].inst.r.funct3 == rv32_exec_pkg::F3_MUL) begin
            s4_word <= s3_prod[W-1:0];
        end else begin
            s4_word <= s3_prod[2*W-1:W];
        end
    end

    always_comb begin
        result = '0;
        if (vld[LAST]) begin
            result.valid = 1'b1;
            result.tag   = ctl[LAST].tag;
            result.inst  = ctl[LAST].inst;
            result.rd_v  = s4_word;
        end
    end

    mul_latency: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> $past(start, rv32_exec_pkg::MUL_STAGES));

endmodule

`default_nettype wire

/* rv32_exec_pkg.sv */
`default_nettype none

package rv32_exec_pkg;

    // datapath and rename tag widths
    localparam int XLEN           = 32;
    localparam int ROB_ADDR_WIDTH = 5;
    localparam int PHYS_REG_BITS  = 6;
    localparam int ARCH_REG_BITS  = 5;

    // fixed unit latencies
    localparam int MUL_STAGES = 4;
    localparam int DIV_CYCLES = 32;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct7 for sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // M extension funct3
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // same word, read as R-type by the arithmetic units and B-type by the branch unit
    typedef union packed {
        r_fmt_t r;
        b_fmt_t b;
    } inst_u;

    typedef struct packed {
        inst_u           inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] i_imm;
        logic            use_imm;
    } decode_info_t;

    typedef struct packed {
        logic [ROB_ADDR_WIDTH-1:0] rob_idx;
        logic [PHYS_REG_BITS-1:0]  pd_s;
        logic [ARCH_REG_BITS-1:0]  rd_s;
    } fu_tag_t;

    typedef struct packed {
        logic            valid;
        fu_tag_t         tag;
        logic [XLEN-1:0] rd_v;
        inst_u           inst;
        logic            pc_select;
        logic [XLEN-1:0] pc_branch;
    } cdb_t;

endpackage

`default_nettype wire

/* tb_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_execute;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 4000;
    // quiet cycles after reset before the first issue
    localparam int IDLE_CYCLES  = 5;
    localparam logic [31:0] MIN_INT = 32'h8000_0000;

    logic clk;
    logic rst;
    logic flush;
    logic start_alu;
    logic start_mul;
    logic start_div;
    logic start_br;
    logic [31:0] rs1_v_alu;
    logic [31:0] rs2_v_alu;
    logic [31:0] rs1_v_mul;
    logic [31:0] rs2_v_mul;
    logic [31:0] rs1_v_div;
    logic [31:0] rs2_v_div;
    logic [31:0] rs1_v_br;
    logic [31:0] rs2_v_br;
    rv32_exec_pkg::decode_info_t decode_alu;
    rv32_exec_pkg::decode_info_t decode_mul;
    rv32_exec_pkg::decode_info_t decode_div;
    rv32_exec_pkg::decode_info_t decode_br;
    rv32_exec_pkg::fu_tag_t tag_alu;
    rv32_exec_pkg::fu_tag_t tag_mul;
    rv32_exec_pkg::fu_tag_t tag_div;
    rv32_exec_pkg::fu_tag_t tag_br;
    rv32_exec_pkg::cdb_t cdb_alu;
    rv32_exec_pkg::cdb_t cdb_mul;
    rv32_exec_pkg::cdb_t cdb_div;
    rv32_exec_pkg::cdb_t cdb_br;
    logic busy_div;

    // expected records keyed by the cycle they should show up in
    rv32_exec_pkg::cdb_t exp_mul [int];
    rv32_exec_pkg::cdb_t exp_div [int];
    rv32_exec_pkg::cdb_t exp_br [int];
    // cycle of the pending divide result, -1 when idle
    int div_end;
    int cyc;
    int checks;
    int cdb_errors;
    int busy_errors;
    logic [31:0] rng_state;

    execute DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // biased toward the values that hit corner cases
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        logic [31:0] v;
        r = lcg_next();
        v = lcg_next();
        case (r[31:29])
            3'd0: v = '0;
            3'd1: v = MIN_INT;
            3'd2: v = '1;
            3'd3: v = v & 32'h0000_00ff;
            default: ;
        endcase
        return v;
    endfunction

    function automatic rv32_exec_pkg::fu_tag_t rand_tag();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];
    endfunction

    function automatic rv32_exec_pkg::decode_info_t alu_decode();
        rv32_exec_pkg::decode_info_t d;
        logic [31:0] w;
        logic [31:0] sel;
        w = lcg_next();
        sel = lcg_next();
        d = '0;
        if (sel[31]) begin
            w[6:0] = rv32_exec_pkg::OP_IMM;
            // shift immediates keep only the legal upper bits
            if (w[13:12] == 2'b01) begin
                w[31:25] = (sel[30] && w[14]) ? rv32_exec_pkg::F7_ALT : 7'd0;
            end
            d.use_imm = 1'b1;
        end else begin
            w[6:0] = rv32_exec_pkg::OP_REG;
            w[31:25] = (sel[30] && (w[14:12] == 3'b000 || w[14:12] == 3'b101)) ?
                       rv32_exec_pkg::F7_ALT : 7'd0;
        end
        d.inst = w;
        d.i_imm = {{20{w[31]}}, w[31:20]};
        d.pc = lcg_next() & 32'hffff_fffc;
        return d;
    endfunction

    // M extension word, funct3[2] picks divide over multiply
    function automatic rv32_exec_pkg::decode_info_t m_decode(input logic is_div);
        rv32_exec_pkg::decode_info_t d;
        logic [31:0] w;
        w = lcg_next();
        w[6:0] = rv32_exec_pkg::OP_REG;
        w[31:25] = 7'b000_0001;
        w[14] = is_div;
        d = '0;
        d.inst = w;
        d.pc = lcg_next() & 32'hffff_fffc;
        return d;
    endfunction

    function automatic rv32_exec_pkg::decode_info_t br_decode();
        rv32_exec_pkg::decode_info_t d;
        logic [31:0] w;
        w = lcg_next();
        w[6:0] = rv32_exec_pkg::OP_BRANCH;
        // 010 and 011 are not branches, fold onto blt and bge
        if (w[14:13] == 2'b01) begin
            w[14] = 1'b1;
            w[13] = 1'b0;
        end
        d = '0;
        d.inst = w;
        d.pc = lcg_next() & 32'hffff_fffc;
        return d;
    endfunction

    function automatic rv32_exec_pkg::cdb_t make_cdb(input rv32_exec_pkg::fu_tag_t tag,
                                                     input rv32_exec_pkg::inst_u inst,
                                                     input logic [31:0] value);
        rv32_exec_pkg::cdb_t c;
        c = '0;
        c.valid = 1'b1;
        c.tag = tag;
        c.rd_v = value;
        c.inst = inst;
        return c;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [31:0] a, input logic [31:0] b_reg,
                                            input rv32_exec_pkg::decode_info_t d);
        logic [31:0] w;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  sh;
        w = d.inst;
        b = d.use_imm ? d.i_imm : b_reg;
        sh = b[4:0];
        case (w[14:12])
            3'd0: res = (w[30] && w[6:0] == rv32_exec_pkg::OP_REG) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = {31'd0, $signed(a) < $signed(b)};
            3'd3: res = {31'd0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (w[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] mul_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] f3);
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] p;
        // rs1 signed except mulhu, rs2 signed for mul and mulh
        xa = {{32{a[31] && f3 != rv32_exec_pkg::F3_MULHU}}, a};
        xb = {{32{b[31] && (f3 == rv32_exec_pkg::F3_MUL || f3 == rv32_exec_pkg::F3_MULH)}}, b};
        p = xa * xb;
        return (f3 == rv32_exec_pkg::F3_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic [2:0] f3);
        logic        is_signed;
        logic [31:0] q;
        logic [31:0] r;
        is_signed = !f3[0];
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end else if (is_signed && a == MIN_INT && b == '1) begin
            q = a;
            r = '0;
        end else if (is_signed) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return f3[1] ? r : q;
    endfunction

    function automatic rv32_exec_pkg::cdb_t br_ref(input logic [31:0] a, input logic [31:0] b,
                                                   input rv32_exec_pkg::decode_info_t d,
                                                   input rv32_exec_pkg::fu_tag_t tag);
        rv32_exec_pkg::cdb_t c;
        logic [31:0] w;
        logic [31:0] off;
        logic        taken;
        w = d.inst;
        off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        case (w[14:12])
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            3'd7: taken = a >= b;
            default: taken = 1'b0;
        endcase
        c = make_cdb(tag, d.inst, 32'd0);
        c.pc_select = taken;
        c.pc_branch = d.pc + (taken ? off : 32'd4);
        return c;
    endfunction

    task automatic check_cdb(input string name, input rv32_exec_pkg::cdb_t got,
                             input rv32_exec_pkg::cdb_t want);
        checks++;
        if (got !== want) begin
            cdb_errors++;
            $display("Error: %s got %h expected %h (cycle %0d)", name, got, want, cyc);
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            busy_errors++;
            $display("Error: %s got %h expected %h (cycle %0d)", name, got, want, cyc);
        end
    endtask

    task automatic drive_inputs(input int n);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] a;
        logic [31:0] b;
        logic        live;
        logic        div_free;
        live = n >= IDLE_CYCLES;
        div_free = !(div_end >= 0 && n < div_end);
        r = lcg_next();
        s = lcg_next();
        flush     <= live && (r[31:16] % 16'd40) == 16'd0;
        start_alu <= live && s[31];
        // mostly back to back multiplies
        start_mul <= live && s[30:29] != 2'b00;
        start_br  <= live && s[28];
        start_div <= live && div_free && s[27:26] == 2'b00;
        rs1_v_alu <= rand_operand();
        rs2_v_alu <= rand_operand();
        rs1_v_mul <= rand_operand();
        rs2_v_mul <= rand_operand();
        decode_alu <= alu_decode();
        decode_mul <= m_decode(1'b0);
        decode_div <= m_decode(1'b1);
        decode_br  <= br_decode();
        tag_alu <= rand_tag();
        tag_mul <= rand_tag();
        tag_div <= rand_tag();
        tag_br  <= rand_tag();
        a = rand_operand();
        b = rand_operand();
        if (s[25:23] == 3'd0) begin
            a = MIN_INT;
            b = '1;
        end
        rs1_v_div <= a;
        rs2_v_div <= b;
        a = rand_operand();
        rs1_v_br <= a;
        rs2_v_br <= s[22] ? a : rand_operand();
    endtask

    task automatic check_cycle(input int n);
        rv32_exec_pkg::cdb_t want;
        want = '0;
        if (start_alu && !flush) begin
            want = make_cdb(tag_alu, decode_alu.inst, alu_ref(rs1_v_alu, rs2_v_alu, decode_alu));
        end
        check_cdb("cdb_alu", cdb_alu, want);
        want = '0;
        if (!flush && exp_mul.exists(n)) want = exp_mul[n];
        check_cdb("cdb_mul", cdb_mul, want);
        want = '0;
        if (!flush && exp_div.exists(n)) want = exp_div[n];
        check_cdb("cdb_div", cdb_div, want);
        want = '0;
        if (!flush && exp_br.exists(n)) want = exp_br[n];
        check_cdb("cdb_br", cdb_br, want);
        check_busy("busy_div", busy_div, div_end >= 0 && n < div_end);

        if (exp_mul.exists(n)) exp_mul.delete(n);
        if (exp_div.exists(n)) exp_div.delete(n);
        if (exp_br.exists(n)) exp_br.delete(n);
        if (div_end >= 0 && n >= div_end) div_end = -1;

        // flush kills everything in flight and nothing issues this cycle
        if (flush) begin
            exp_mul.delete();
            exp_div.delete();
            exp_br.delete();
            div_end = -1;
        end else begin
            if (start_mul) begin
                exp_mul[n + rv32_exec_pkg::MUL_STAGES] = make_cdb(tag_mul, decode_mul.inst,
                    mul_ref(rs1_v_mul, rs2_v_mul, decode_mul.inst.r.funct3));
            end
            if (start_div) begin
                div_end = n + rv32_exec_pkg::DIV_CYCLES + 1;
                exp_div[div_end] = make_cdb(tag_div, decode_div.inst,
                    div_ref(rs1_v_div, rs2_v_div, decode_div.inst.r.funct3));
            end
            if (start_br) begin
                exp_br[n + 1] = br_ref(rs1_v_br, rs2_v_br, decode_br, tag_br);
            end
        end
    endtask

    initial begin
        rng_state = 32'h5860830d;
        div_end = -1;
        checks = 0;
        cdb_errors = 0;
        busy_errors = 0;
        cyc = 0;
        rst = 1'b1;
        flush = 1'b0;
        start_alu = 1'b0;
        start_mul = 1'b0;
        start_div = 1'b0;
        start_br = 1'b0;
        rs1_v_alu = '0;
        rs2_v_alu = '0;
        rs1_v_mul = '0;
        rs2_v_mul = '0;
        rs1_v_div = '0;
        rs2_v_div = '0;
        rs1_v_br = '0;
        rs2_v_br = '0;
        decode_alu = '0;
        decode_mul = '0;
        decode_div = '0;
        decode_br = '0;
        tag_alu = '0;
        tag_mul = '0;
        tag_div = '0;
        tag_br = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            drive_inputs(cyc);
            @(negedge clk);
            check_cycle(cyc);
            @(posedge clk);
        end

        $display("checks %0d, cdb errors %0d, busy errors %0d",
                 checks, cdb_errors, busy_errors);
        if (cdb_errors + busy_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the test length
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog timeout, the test did not reach its end in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
